// File: rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    ////////////////////////////////////////
    // Opcodes and funct codes
    ////////////////////////////////////////
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } instr_j_t;

    // Same 32 bits, three formats
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

    ////////////////////////////////////////
    // Decoded control
    ////////////////////////////////////////
    typedef enum logic [1:0] {ext_zero, ext_sign, ext_upper} ext_e;
    typedef enum logic [1:0] {alu_add, alu_sub, alu_or, alu_pass_b} alu_op_e;
    typedef enum logic [1:0] {wd_alu, wd_mem, wd_pc8} wd_sel_e;

    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] dest;        // 0 when nothing is written
        logic       reg_we;
        wd_sel_e    wd_sel;
        alu_op_e    alu_op;
        logic       alu_src_imm;
        ext_e       ext;
        logic       mem_we;
        logic       is_branch;
        logic       is_jump;     // j and jal
        logic       is_jr;
        logic       use_rs_d;    // Needed by compare or jr
        logic       use_rt_d;
        logic       use_rs_e;    // Needed by the ALU
        logic       use_rt_e;
    } ctrl_t;

endpackage

// File: rtl/mips_pipe_pkg.sv
package mips_pipe_pkg;

    localparam logic [31:0] reset_pc = 32'h0000_3000;

    ////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////
    typedef struct packed {
        mips_isa_pkg::instr_u instr;
        logic [31:0]          pc;
        logic                 valid;
    } dreg_t;

    typedef struct packed {
        mips_isa_pkg::instr_u instr;
        logic [31:0]          pc;
        logic [31:0]          rs_val;
        logic [31:0]          rt_val;
        logic [31:0]          imm;      // Already extended
        logic                 valid;
    } ereg_t;

    typedef struct packed {
        mips_isa_pkg::instr_u instr;
        logic [31:0]          pc;
        logic [31:0]          alu_res;
        logic [31:0]          rt_val;
        logic                 valid;
    } mreg_t;

    typedef struct packed {
        mips_isa_pkg::instr_u instr;
        logic [31:0]          pc;
        logic [31:0]          alu_res;
        logic [31:0]          mem_data;
        logic                 valid;
    } wreg_t;

    // Operand source
    typedef enum logic [1:0] {fwd_rf, fwd_e, fwd_m, fwd_w} fwd_sel_e;

    ////////////////////////////////////////
    // Trace events
    ////////////////////////////////////////
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  dest;
        logic [31:0] data;
    } reg_event_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] data;
    } store_event_t;

endpackage

// File: rtl/mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder (
    input  mips_isa_pkg::instr_u instr,
    output mips_isa_pkg::ctrl_t  ctrl
);
    import mips_isa_pkg::*;

    always_comb begin
        ctrl    = '0;                  // Anything unknown stays a nop
        ctrl.rs = instr.r.rs;
        ctrl.rt = instr.r.rt;

        unique case (instr.r.op)
            op_special: begin
                unique case (instr.r.funct)
                    fn_addu: begin
                        ctrl.dest     = instr.r.rd;
                        ctrl.reg_we   = 1'b1;
                        ctrl.alu_op   = alu_add;
                        ctrl.use_rs_e = 1'b1;
                        ctrl.use_rt_e = 1'b1;
                    end
                    fn_subu: begin
                        ctrl.dest     = instr.r.rd;
                        ctrl.reg_we   = 1'b1;
                        ctrl.alu_op   = alu_sub;
                        ctrl.use_rs_e = 1'b1;
                        ctrl.use_rt_e = 1'b1;
                    end
                    fn_jr: begin
                        ctrl.is_jr    = 1'b1;
                        ctrl.use_rs_d = 1'b1;  // Target resolved in decode
                    end
                    default: ;                 // sll 0 and the rest
                endcase
            end
            op_ori: begin
                ctrl.dest        = instr.i.rt;
                ctrl.reg_we      = 1'b1;
                ctrl.alu_op      = alu_or;
                ctrl.alu_src_imm = 1'b1;
                ctrl.ext         = ext_zero;
                ctrl.use_rs_e    = 1'b1;
            end
            op_lui: begin
                ctrl.dest        = instr.i.rt;
                ctrl.reg_we      = 1'b1;
                ctrl.alu_op      = alu_pass_b;
                ctrl.alu_src_imm = 1'b1;
                ctrl.ext         = ext_upper;
            end
            op_lw: begin
                ctrl.dest        = instr.i.rt;
                ctrl.reg_we      = 1'b1;
                ctrl.wd_sel      = wd_mem;
                ctrl.alu_op      = alu_add;
                ctrl.alu_src_imm = 1'b1;
                ctrl.ext         = ext_sign;
                ctrl.use_rs_e    = 1'b1;
            end
            op_sw: begin
                // Store data is only needed in M
                ctrl.mem_we      = 1'b1;
                ctrl.alu_op      = alu_add;
                ctrl.alu_src_imm = 1'b1;
                ctrl.ext         = ext_sign;
                ctrl.use_rs_e    = 1'b1;
            end
            op_beq: begin
                ctrl.is_branch = 1'b1;
                ctrl.ext       = ext_sign;
                ctrl.use_rs_d  = 1'b1;
                ctrl.use_rt_d  = 1'b1;
            end
            op_j: ctrl.is_jump = 1'b1;
            op_jal: begin
                ctrl.is_jump = 1'b1;
                ctrl.dest    = 5'd31;          // Link register
                ctrl.reg_we  = 1'b1;
                ctrl.wd_sel  = wd_pc8;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/mips_hazard_unit.sv
`timescale 1ns/1ps

module mips_hazard_unit (
    input  mips_isa_pkg::ctrl_t     d_ctrl,
    input  mips_isa_pkg::ctrl_t     e_ctrl,
    input  mips_isa_pkg::ctrl_t     m_ctrl,
    input  mips_isa_pkg::ctrl_t     w_ctrl,
    output logic                    stall,
    output mips_pipe_pkg::fwd_sel_e fwd_rs_d,
    output mips_pipe_pkg::fwd_sel_e fwd_rt_d,
    output mips_pipe_pkg::fwd_sel_e fwd_rs_e,
    output mips_pipe_pkg::fwd_sel_e fwd_rt_e
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    // Stage with control c will write register r
    function automatic logic writes(input ctrl_t c, input logic [4:0] r);
        return c.reg_we && (c.dest != 5'd0) && (c.dest == r);
    endfunction

    // Nearest writer decides; if its value is not ready yet, keep the old one
    function automatic fwd_sel_e pick(input logic [4:0] r, input ctrl_t e,
                                      input ctrl_t m, input ctrl_t w);
        fwd_sel_e sel;
        sel = fwd_rf;
        if (writes(e, r)) begin
            if (e.wd_sel == wd_pc8) sel = fwd_e;   // Only pc+8 is known in E
        end else if (writes(m, r)) begin
            if (m.wd_sel != wd_mem) sel = fwd_m;
        end else if (writes(w, r)) begin
            sel = fwd_w;
        end
        return sel;
    endfunction

    // Not ready for a decode-time use
    function automatic logic late_d(input logic [4:0] r, input ctrl_t e, input ctrl_t m);
        return (writes(e, r) && e.wd_sel != wd_pc8) ||
               (writes(m, r) && m.wd_sel == wd_mem);
    endfunction

    // Not ready for an execute-time use, i.e. a load still in E
    function automatic logic late_e(input logic [4:0] r, input ctrl_t e);
        return writes(e, r) && (e.wd_sel == wd_mem);
    endfunction

    assign fwd_rs_d = pick(d_ctrl.rs, e_ctrl, m_ctrl, w_ctrl);
    assign fwd_rt_d = pick(d_ctrl.rt, e_ctrl, m_ctrl, w_ctrl);
    assign fwd_rs_e = pick(e_ctrl.rs, '0, m_ctrl, w_ctrl);  // Nothing ahead of E here
    assign fwd_rt_e = pick(e_ctrl.rt, '0, m_ctrl, w_ctrl);

    assign stall = (d_ctrl.use_rs_d && late_d(d_ctrl.rs, e_ctrl, m_ctrl)) ||
                   (d_ctrl.use_rt_d && late_d(d_ctrl.rt, e_ctrl, m_ctrl)) ||
                   (d_ctrl.use_rs_e && late_e(d_ctrl.rs, e_ctrl)) ||
                   (d_ctrl.use_rt_e && late_e(d_ctrl.rt, e_ctrl));

endmodule

// File: rtl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    input  logic        we
);

    logic [31:0] regs [32];
    logic        wr_ok;

    assign wr_ok = we && (wa != 5'd0);  // r0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wa] <= wd;
        end
    end

    // Write before read
    assign rd1 = (wr_ok && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (wr_ok && wa == ra2) ? wd : regs[ra2];

endmodule

// File: rtl/mips_data_mem.sv
`timescale 1ns/1ps

module mips_data_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] addr,
    input  logic [31:0] wd,
    input  logic        we,
    output logic [31:0] rd
);

    logic [31:0] mem [1024];
    logic [9:0]  idx;

    assign idx = addr[11:2];   // Word index, low bits ignored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wd;
        end
    end

    // Read path is combinational
    assign rd = mem[idx];

endmodule

// File: rtl/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [31:0]                 imem_addr,
    input  mips_isa_pkg::instr_u        imem_data,
    output mips_pipe_pkg::reg_event_t   reg_event,
    output mips_pipe_pkg::store_event_t store_event
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [31:0] pc, npc;
    dreg_t       dreg;
    ereg_t       ereg;
    mreg_t       mreg;
    wreg_t       wreg;
    ctrl_t       d_ctrl, e_ctrl, m_ctrl, w_ctrl;
    logic        stall;
    fwd_sel_e    fwd_rs_d, fwd_rt_d, fwd_rs_e, fwd_rt_e;
    logic [31:0] rd1, rd2, d_rs_v, d_rt_v, d_imm;
    logic [31:0] e_wd, m_wd, w_wd;
    logic [31:0] e_rs_v, e_rt_v, alu_b, alu_res;
    logic [31:0] m_store, dm_rd;

    function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] rf,
                                            input logic [31:0] e, input logic [31:0] m,
                                            input logic [31:0] w);
        unique case (sel)
            fwd_e:   return e;
            fwd_m:   return m;
            fwd_w:   return w;
            default: return rf;
        endcase
    endfunction

    mips_decoder i_dec_d (.instr(dreg.instr), .ctrl(d_ctrl));
    mips_decoder i_dec_e (.instr(ereg.instr), .ctrl(e_ctrl));
    mips_decoder i_dec_m (.instr(mreg.instr), .ctrl(m_ctrl));
    mips_decoder i_dec_w (.instr(wreg.instr), .ctrl(w_ctrl));

    mips_hazard_unit i_hazard (
        .d_ctrl(d_ctrl), .e_ctrl(e_ctrl), .m_ctrl(m_ctrl), .w_ctrl(w_ctrl),
        .stall(stall),
        .fwd_rs_d(fwd_rs_d), .fwd_rt_d(fwd_rt_d),
        .fwd_rs_e(fwd_rs_e), .fwd_rt_e(fwd_rt_e)
    );

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= reset_pc;
            dreg <= '0;
        end else if (!stall) begin   // Stall freezes F and D
            pc         <= npc;
            dreg.instr <= imem_data;
            dreg.pc    <= pc;
            dreg.valid <= 1'b1;
        end
    end

    assign imem_addr = pc;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    mips_regfile i_regfile (
        .clk(clk), .rst_n(rst_n),
        .ra1(d_ctrl.rs), .ra2(d_ctrl.rt), .rd1(rd1), .rd2(rd2),
        .wa(w_ctrl.dest), .wd(w_wd), .we(w_ctrl.reg_we && wreg.valid)
    );

    assign d_rs_v = fwd_mux(fwd_rs_d, rd1, e_wd, m_wd, w_wd);
    assign d_rt_v = fwd_mux(fwd_rt_d, rd2, e_wd, m_wd, w_wd);

    always_comb begin
        unique case (d_ctrl.ext)
            ext_sign:  d_imm = {{16{dreg.instr.i.imm[15]}}, dreg.instr.i.imm};
            ext_upper: d_imm = {dreg.instr.i.imm, 16'h0000};
            default:   d_imm = {16'h0000, dreg.instr.i.imm};
        endcase
    end

    // pc already points at the delay slot
    always_comb begin
        npc = pc + 32'd4;
        if (d_ctrl.is_jr) begin
            npc = d_rs_v;
        end else if (d_ctrl.is_jump) begin
            npc = {pc[31:28], dreg.instr.j.target, 2'b00};
        end else if (d_ctrl.is_branch && (d_rs_v == d_rt_v)) begin
            npc = pc + {d_imm[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ereg <= '0;
        end else if (stall) begin
            ereg <= '0;              // Bubble, decodes as nop
        end else begin
            ereg.instr  <= dreg.instr;
            ereg.pc     <= dreg.pc;
            ereg.rs_val <= d_rs_v;
            ereg.rt_val <= d_rt_v;
            ereg.imm    <= d_imm;
            ereg.valid  <= dreg.valid;
        end
    end

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////
    assign e_wd   = ereg.pc + 32'd8;   // Only the link value is ready here
    assign e_rs_v = fwd_mux(fwd_rs_e, ereg.rs_val, ereg.rs_val, m_wd, w_wd);
    assign e_rt_v = fwd_mux(fwd_rt_e, ereg.rt_val, ereg.rt_val, m_wd, w_wd);
    assign alu_b  = e_ctrl.alu_src_imm ? ereg.imm : e_rt_v;

    always_comb begin
        unique case (e_ctrl.alu_op)
            alu_sub:    alu_res = e_rs_v - alu_b;
            alu_or:     alu_res = e_rs_v | alu_b;
            alu_pass_b: alu_res = alu_b;
            default:    alu_res = e_rs_v + alu_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mreg <= '0;
        end else begin
            mreg.instr   <= ereg.instr;
            mreg.pc      <= ereg.pc;
            mreg.alu_res <= alu_res;
            mreg.rt_val  <= e_rt_v;
            mreg.valid   <= ereg.valid;
        end
    end

    ////////////////////////////////////////
    // Memory
    ////////////////////////////////////////
    assign m_wd = (m_ctrl.wd_sel == wd_pc8) ? mreg.pc + 32'd8 : mreg.alu_res;

    // Load result one ahead reaches a store here
    assign m_store = (w_ctrl.reg_we && w_ctrl.dest != 5'd0 && w_ctrl.dest == m_ctrl.rt)
                     ? w_wd : mreg.rt_val;

    mips_data_mem i_data_mem (
        .clk(clk), .rst_n(rst_n),
        .addr(mreg.alu_res), .wd(m_store),
        .we(m_ctrl.mem_we && mreg.valid), .rd(dm_rd)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wreg <= '0;
        end else begin
            wreg.instr    <= mreg.instr;
            wreg.pc       <= mreg.pc;
            wreg.alu_res  <= mreg.alu_res;
            wreg.mem_data <= dm_rd;
            wreg.valid    <= mreg.valid;
        end
    end

    ////////////////////////////////////////
    // Writeback and trace
    ////////////////////////////////////////
    always_comb begin
        unique case (w_ctrl.wd_sel)
            wd_mem:  w_wd = wreg.mem_data;
            wd_pc8:  w_wd = wreg.pc + 32'd8;
            default: w_wd = wreg.alu_res;
        endcase
    end

    assign reg_event.valid = wreg.valid && w_ctrl.reg_we && (w_ctrl.dest != 5'd0);
    assign reg_event.pc    = wreg.pc;
    assign reg_event.dest  = w_ctrl.dest;
    assign reg_event.data  = w_wd;

    assign store_event.valid = mreg.valid && m_ctrl.mem_we;
    assign store_event.pc    = mreg.pc;
    assign store_event.addr  = mreg.alu_res;
    assign store_event.data  = m_store;

endmodule

// File: dv/mips_clk_gen.sv
`timescale 1ns/1ps

module mips_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;             // Released just after the 5th edge
    end

endmodule

// File: dv/mips_core_asserts.sv
`timescale 1ns/1ps

module mips_core_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        stall,
    input logic [31:0]                 imem_addr,
    input mips_pipe_pkg::reg_event_t   reg_event,
    input mips_pipe_pkg::store_event_t store_event
);

    // Writes to r0 never show up in the trace
    a_no_r0_event: assert property (@(posedge clk) disable iff (!rst_n)
        reg_event.valid |-> reg_event.dest != 5'd0)
        else $error("reg_event reported register 0 at pc %h", reg_event.pc);

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !reg_event.valid && !store_event.valid)
        else $error("trace event seen while in reset");

    // Fetch frozen
    a_fetch_held: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(imem_addr))
        else $error("imem_addr moved after a stall cycle");

endmodule

// File: dv/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    // Key holds dest for register events and addr for stores
    typedef struct packed {
        logic        is_store;
        logic [31:0] pc;
        logic [31:0] key;
        logic [31:0] data;
    } trace_t;

    logic         clk;
    logic         rst_n;
    logic [31:0]  imem_addr;
    instr_u       imem_data = '0;
    reg_event_t   reg_event;
    store_event_t store_event;

    logic [31:0]  prog [$];
    trace_t       exp_q [$];
    trace_t       got_q [$];
    int           checks = 0;
    int           errors = 0;

    mips_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    mips_core i_mips_core (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .reg_event(reg_event), .store_event(store_event)
    );

    bind mips_core mips_core_asserts i_core_asserts (
        .clk(clk), .rst_n(rst_n), .stall(stall), .imem_addr(imem_addr),
        .reg_event(reg_event), .store_event(store_event)
    );

    ////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////
    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [5:0] op, input logic [31:0] addr);
        return {op, addr[27:2]};
    endfunction

    task automatic expect_reg(input logic [31:0] pc, input logic [4:0] dest,
                              input logic [31:0] data);
        exp_q.push_back({1'b0, pc, 27'd0, dest, data});
    endtask

    task automatic expect_store(input logic [31:0] pc, input logic [31:0] addr,
                                input logic [31:0] data);
        exp_q.push_back({1'b1, pc, addr, data});
    endtask

    task automatic load_program();
        prog.push_back(i_type(op_ori, 5'd0, 5'd1, 16'h1234));    // 3000
        prog.push_back(i_type(op_lui, 5'd0, 5'd2, 16'h8000));
        prog.push_back(i_type(op_ori, 5'd0, 5'd3, 16'hffff));
        prog.push_back(r_type(5'd2, 5'd2, 5'd4, fn_addu));        // Wraps to 0
        prog.push_back(r_type(5'd1, 5'd3, 5'd5, fn_subu));        // 3010
        prog.push_back(r_type(5'd5, 5'd3, 5'd6, fn_addu));        // Chain from M
        prog.push_back(r_type(5'd6, 5'd5, 5'd7, fn_subu));        // M and W
        prog.push_back(i_type(op_ori, 5'd0, 5'd8, 16'h0100));
        prog.push_back(i_type(op_sw, 5'd8, 5'd7, 16'h0004));      // 3020
        prog.push_back(i_type(op_lw, 5'd8, 5'd9, 16'h0004));
        prog.push_back(r_type(5'd9, 5'd7, 5'd10, fn_addu));       // Load use stall
        prog.push_back(i_type(op_sw, 5'd8, 5'd10, 16'h0008));
        prog.push_back(i_type(op_beq, 5'd10, 5'd9, 16'h0002));    // 3030 not taken
        prog.push_back(i_type(op_ori, 5'd0, 5'd11, 16'h0011));
        prog.push_back(i_type(op_beq, 5'd11, 5'd11, 16'h0002));   // Taken to 3044
        prog.push_back(i_type(op_ori, 5'd0, 5'd12, 16'h0022));
        prog.push_back(i_type(op_ori, 5'd0, 5'd12, 16'hdead));    // 3040 skipped
        prog.push_back(j_type(op_jal, 32'h0000_3058));
        prog.push_back(i_type(op_ori, 5'd0, 5'd13, 16'h0033));
        prog.push_back(r_type(5'd31, 5'd0, 5'd14, fn_addu));      // Return point
        prog.push_back(j_type(op_j, 32'h0000_3064));              // 3050
        prog.push_back(i_type(op_ori, 5'd0, 5'd0, 16'hffff));     // r0 target
        prog.push_back(r_type(5'd31, 5'd0, 5'd0, fn_jr));
        prog.push_back(r_type(5'd1, 5'd1, 5'd0, fn_addu));        // r0 target
        prog.push_back(i_type(op_ori, 5'd0, 5'd12, 16'hbad0));    // 3060 skipped
        prog.push_back(r_type(5'd0, 5'd1, 5'd15, fn_addu));
    endtask

    // Expected events in retirement order
    task automatic load_expected();
        expect_reg(32'h3000, 5'd1, 32'h0000_1234);
        expect_reg(32'h3004, 5'd2, 32'h8000_0000);
        expect_reg(32'h3008, 5'd3, 32'h0000_ffff);
        expect_reg(32'h300c, 5'd4, 32'h0000_0000);
        expect_reg(32'h3010, 5'd5, 32'hffff_1235);
        expect_reg(32'h3014, 5'd6, 32'h0000_1234);
        expect_reg(32'h3018, 5'd7, 32'h0000_ffff);
        expect_reg(32'h301c, 5'd8, 32'h0000_0100);
        expect_store(32'h3020, 32'h0000_0104, 32'h0000_ffff);
        expect_reg(32'h3024, 5'd9, 32'h0000_ffff);
        expect_reg(32'h3028, 5'd10, 32'h0001_fffe);
        expect_store(32'h302c, 32'h0000_0108, 32'h0001_fffe);
        expect_reg(32'h3034, 5'd11, 32'h0000_0011);
        expect_reg(32'h303c, 5'd12, 32'h0000_0022);
        expect_reg(32'h3044, 5'd31, 32'h0000_304c);   // jal link
        expect_reg(32'h3048, 5'd13, 32'h0000_0033);
        expect_reg(32'h304c, 5'd14, 32'h0000_304c);
        expect_reg(32'h3064, 5'd15, 32'h0000_1234);
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - reset_pc) >> 2;
        if (addr < reset_pc || idx >= prog.size()) begin
            return 32'h0000_0000;                      // nop past the end
        end
        return prog[idx];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    ////////////////////////////////////////
    // Instruction memory and trace capture
    ////////////////////////////////////////
    always @(posedge clk) begin
        #1;
        imem_data <= fetch_word(imem_addr);
    end

    // W is older than M and is queued first
    always @(negedge clk) begin
        if (rst_n && reg_event.valid) begin
            got_q.push_back({1'b0, reg_event.pc, 27'd0, reg_event.dest, reg_event.data});
        end
        if (rst_n && store_event.valid) begin
            got_q.push_back({1'b1, store_event.pc, store_event.addr, store_event.data});
        end
    end

    initial begin
        trace_t want;
        trace_t seen;
        string  sig;
        string  field;
        int     limit;
        load_program();
        load_expected();
        limit = (prog.size() + 20) * 10;

        // Watchdog
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("ERROR: timeout after %0d cycles, %0d events still pending",
                         limit, exp_q.size());
                $display("checks %0d, errors %0d", checks, errors + 1);
                $display("Simulation failed");
                $finish;
            end
        join_none

        while (exp_q.size() != 0) begin
            want = exp_q[0];
            while (got_q.size() == 0) begin
                @(posedge clk);
            end
            seen = got_q.pop_front();
            if (seen.is_store != want.is_store) begin
                errors++;
                $display("ERROR: wanted a %s event for pc %h, a %s event for pc %h came first",
                         want.is_store ? "store" : "register", want.pc,
                         seen.is_store ? "store" : "register", seen.pc);
            end else begin
                sig   = want.is_store ? "store_event" : "reg_event";
                field = want.is_store ? ".addr" : ".dest";
                check_value({sig, ".pc"}, seen.pc, want.pc);
                check_value({sig, field}, seen.key, want.key);
                check_value({sig, ".data"}, seen.data, want.data);
            end
            exp_q.delete(0);
        end

        // Nothing more may show up once the pipeline drains
        repeat (20) @(posedge clk);
        if (got_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d unexpected events after the last expected one, first at pc %h",
                     got_q.size(), got_q[0].pc);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: flist.f
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/mips_decoder.sv
rtl/mips_hazard_unit.sv
rtl/mips_regfile.sv
rtl/mips_data_mem.sv
rtl/mips_core.sv
dv/mips_clk_gen.sv
dv/mips_core_asserts.sv
dv/mips_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := mips_core_tb
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
